// File: common/dbus_pkg.sv
`default_nettype none

package dbus_pkg;

    localparam int BYTE_LANES = 4;

    // One byte lane of the data bus
    typedef logic [7:0] byte_t;

    // Bit i enables bits 8i+7..8i of a word
    typedef logic [BYTE_LANES-1:0] byte_en_t;

    // Byte offset within a word, addr[1:0]
    typedef logic [1:0] byte_off_t;

    localparam byte_en_t LANES_NONE = 4'b0000;
    localparam byte_en_t LANES_ALL  = 4'b1111;
    localparam byte_en_t LANES_LOW  = 4'b0011;
    localparam byte_en_t LANES_HIGH = 4'b1100;

endpackage

`default_nettype wire

// File: common/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Word index width of the data memory
`define DMEM_ADDR_BITS 8

// Words per byte bank
`define DMEM_WORDS (1 << `DMEM_ADDR_BITS)

`endif

// File: common/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] word_t;

    // Memory operation carried with each request
    typedef enum logic [3:0] {
        NOP = 4'd0,
        LB  = 4'd1,
        LBU = 4'd2,
        LH  = 4'd3,
        LHU = 4'd4,
        LW  = 4'd5,
        LWL = 4'd6,
        LWR = 4'd7,
        SB  = 4'd8,
        SH  = 4'd9,
        SW  = 4'd10,
        SWL = 4'd11,
        SWR = 4'd12
    } mem_op_t;

    function automatic logic is_load(input mem_op_t op);
        case (op)
            LB, LBU, LH, LHU, LW, LWL, LWR: is_load = 1'b1;
            default: is_load = 1'b0;
        endcase
    endfunction

    function automatic logic is_store(input mem_op_t op);
        case (op)
            SB, SH, SW, SWL, SWR: is_store = 1'b1;
            default: is_store = 1'b0;
        endcase
    endfunction

    // Word and half ops must be naturally aligned
    function automatic logic is_misaligned(input mem_op_t op, input logic [1:0] offset);
        case (op)
            LW, SW: is_misaligned = (offset != 2'b00);
            LH, LHU, SH: is_misaligned = offset[0];
            default: is_misaligned = 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: logic/byte_bank.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_settings.svh"

module byte_bank
    import dbus_pkg::*;
(
    input  logic                       clk,
    input  logic                       we,
    input  logic [`DMEM_ADDR_BITS-1:0] index,
    input  byte_t                      wdata,
    output byte_t                      rdata
);

    byte_t mem [`DMEM_WORDS];

    // Read returns the old byte when the same index is written
    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
        rdata <= mem[index];
    end

endmodule

`default_nettype wire

// File: logic/mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_settings.svh"

module mem_stage
    import mips_isa_pkg::*, dbus_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    req,
    input  mem_op_t op,
    input  word_t   addr,
    input  word_t   srcb,
    output word_t   rdata,
    output logic    rdata_valid,
    output logic    addr_error
);

    byte_en_t                   bank_we;
    word_t                      bank_wdata;
    logic [`DMEM_ADDR_BITS-1:0] bank_addr;
    logic                       rd_en;
    word_t                      lane_data;

    writedata_format u_format (
        .op         (op),
        .addr       (addr),
        .srcb       (srcb),
        .req        (req),
        .bank_we    (bank_we),
        .bank_wdata (bank_wdata),
        .bank_addr  (bank_addr),
        .rd_en      (rd_en),
        .addr_error (addr_error)
    );

    // Lane i holds bits 8i+7..8i of every word
    for (genvar i = 0; i < BYTE_LANES; i++) begin : g_bank
        byte_bank u_bank (
            .clk   (clk),
            .we    (bank_we[i]),
            .index (bank_addr),
            .wdata (bank_wdata[8*i +: 8]),
            .rdata (lane_data[8*i +: 8])
        );
    end

    readdata_extract u_extract (
        .clk         (clk),
        .reset       (reset),
        .rd_en       (rd_en),
        .op          (op),
        .offset      (addr[1:0]),
        .srcb        (srcb),
        .lane_data   (lane_data),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

endmodule

`default_nettype wire

// File: logic/readdata_extract.sv
`timescale 1ns/100ps
`default_nettype none

module readdata_extract
    import mips_isa_pkg::*, dbus_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      rd_en,
    input  mem_op_t   op,
    input  byte_off_t offset,
    input  word_t     srcb,
    input  word_t     lane_data,
    output word_t     rdata,
    output logic      rdata_valid
);

    mem_op_t     op_q;
    byte_off_t   offset_q;
    word_t       srcb_q;
    logic        valid_q;
    byte_t       sel_byte;
    logic [15:0] sel_half;
    word_t       lwl_word;
    word_t       lwr_word;

    // Control follows the bank read by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q  <= 1'b0;
            op_q     <= NOP;
            offset_q <= 2'b00;
        end else begin
            valid_q <= rd_en;
            if (rd_en) begin
                op_q     <= op;
                offset_q <= offset;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            srcb_q <= srcb; // Merge source for LWL/LWR
        end
    end

    assign sel_byte = lane_data[{offset_q, 3'b000} +: 8];
    assign sel_half = lane_data[{offset_q[1], 4'b0000} +: 16];

    // Memory bytes 0..k fill the top of the register
    always_comb begin
        case (offset_q)
            2'b00: lwl_word = {lane_data[7:0], srcb_q[23:0]};
            2'b01: lwl_word = {lane_data[15:0], srcb_q[15:0]};
            2'b10: lwl_word = {lane_data[23:0], srcb_q[7:0]};
            default: lwl_word = lane_data;
        endcase
    end

    // Memory bytes k..3 fill the bottom of the register
    always_comb begin
        case (offset_q)
            2'b00: lwr_word = lane_data;
            2'b01: lwr_word = {srcb_q[31:24], lane_data[31:8]};
            2'b10: lwr_word = {srcb_q[31:16], lane_data[31:16]};
            default: lwr_word = {srcb_q[31:8], lane_data[31:24]};
        endcase
    end

    always_comb begin
        case (op_q)
            LB: rdata = {{24{sel_byte[7]}}, sel_byte};
            LBU: rdata = {24'h000000, sel_byte};
            LH: rdata = {{16{sel_half[15]}}, sel_half};
            LHU: rdata = {16'h0000, sel_half};
            LWL: rdata = lwl_word;
            LWR: rdata = lwr_word;
            default: rdata = lane_data; // LW
        endcase
    end

    assign rdata_valid = valid_q;

endmodule

`default_nettype wire

// File: logic/writedata_format.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_settings.svh"

module writedata_format
    import mips_isa_pkg::*, dbus_pkg::*;
(
    input  mem_op_t                    op,
    input  word_t                      addr,
    input  word_t                      srcb,
    input  logic                       req,
    output byte_en_t                   bank_we,
    output word_t                      bank_wdata,
    output logic [`DMEM_ADDR_BITS-1:0] bank_addr,
    output logic                       rd_en,
    output logic                       addr_error
);

    byte_off_t offset;
    byte_en_t  lane_en;
    word_t     shifted;
    logic      misaligned;

    assign offset     = addr[1:0];
    assign bank_addr  = addr[`DMEM_ADDR_BITS+1:2]; // Word index
    assign misaligned = is_misaligned(op, offset);

    always_comb begin
        lane_en = LANES_NONE;
        shifted = srcb;
        case (op)
            SW: begin
                lane_en = LANES_ALL;
            end
            SH: begin
                if (offset[1]) begin
                    lane_en = LANES_HIGH;
                    shifted = {srcb[15:0], 16'h0000};
                end else begin
                    lane_en = LANES_LOW;
                end
            end
            SB: begin
                case (offset)
                    2'b00: begin
                        lane_en = 4'b0001;
                    end
                    2'b01: begin
                        lane_en = 4'b0010;
                        shifted = {srcb[23:0], 8'h00};
                    end
                    2'b10: begin
                        lane_en = 4'b0100;
                        shifted = {srcb[15:0], 16'h0000};
                    end
                    default: begin
                        lane_en = 4'b1000;
                        shifted = {srcb[7:0], 24'h000000};
                    end
                endcase
            end
            SWL: begin
                // Top bytes of srcb land on lanes offset down to 0
                case (offset)
                    2'b00: begin
                        lane_en = 4'b0001;
                        shifted = {24'h000000, srcb[31:24]};
                    end
                    2'b01: begin
                        lane_en = 4'b0011;
                        shifted = {16'h0000, srcb[31:16]};
                    end
                    2'b10: begin
                        lane_en = 4'b0111;
                        shifted = {8'h00, srcb[31:8]};
                    end
                    default: begin
                        lane_en = LANES_ALL;
                    end
                endcase
            end
            SWR: begin
                // Low bytes of srcb land on lanes offset up to 3
                case (offset)
                    2'b00: begin
                        lane_en = LANES_ALL;
                    end
                    2'b01: begin
                        lane_en = 4'b1110;
                        shifted = {srcb[23:0], 8'h00};
                    end
                    2'b10: begin
                        lane_en = LANES_HIGH;
                        shifted = {srcb[15:0], 16'h0000};
                    end
                    default: begin
                        lane_en = 4'b1000;
                        shifted = {srcb[7:0], 24'h000000};
                    end
                endcase
            end
            default: begin
                lane_en = LANES_NONE;
            end
        endcase
    end

    assign bank_wdata = shifted;

    // Misaligned requests touch no memory
    assign bank_we    = (req && is_store(op) && !misaligned) ? lane_en : LANES_NONE;
    assign rd_en      = req && is_load(op) && !misaligned;
    assign addr_error = req && misaligned;

endmodule

`default_nettype wire

// File: mips_dmem.f
+incdir+common
common/mips_isa_pkg.sv
common/dbus_pkg.sv
logic/writedata_format.sv
logic/byte_bank.sv
logic/readdata_extract.sv
logic/mem_stage.sv
tests/mem_stage_tb.sv

// File: tests/mem_stage_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_settings.svh"

module mem_stage_tb
    import mips_isa_pkg::*, dbus_pkg::*;
;

    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 5;
    localparam int WORD_TRIPS      = 16;
    localparam int MIXED_OPS       = 24;
    // Request cycles over all tests including each idle flush
    localparam int TOTAL_REQS      = (2 * WORD_TRIPS + 1) + 19 + 27 + 34 + 8 + (MIXED_OPS + 7);
    localparam int WATCHDOG_MARGIN = 20 * CLK_PERIOD;

    logic    clk;
    logic    reset;
    logic    req;
    mem_op_t op;
    word_t   addr;
    word_t   srcb;
    word_t   rdata;
    logic    rdata_valid;
    logic    addr_error;

    byte_t   ref_mem [4*`DMEM_WORDS]; // Byte-addressed model of the memory
    logic    pending;                 // A load result is due in the next cycle
    word_t   pending_word;
    string   test_name;

    mem_stage dut (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .op          (op),
        .addr        (addr),
        .srcb        (srcb),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .addr_error  (addr_error)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((RESET_CYCLES + TOTAL_REQS) * CLK_PERIOD + WATCHDOG_MARGIN);
        $display("Timeout: the tests did not finish in the expected number of cycles");
        $display("TEST FAIL");
        $fatal(1, "Watchdog expired");
    end

    task automatic compare(input string what, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s (%s): expected %h, actual %h",
                     test_name, what, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "Stopping at the first error");
        end
    endtask

    function automatic logic op_loads(input mem_op_t o);
        case (o)
            LB, LBU, LH, LHU, LW, LWL, LWR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic op_stores(input mem_op_t o);
        case (o)
            SB, SH, SW, SWL, SWR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Word ops need offset 0, half ops an even offset
    function automatic logic expect_error(input mem_op_t o, input logic [1:0] k);
        case (o)
            LW, SW: return k != 2'd0;
            LH, LHU, SH: return k[0];
            default: return 1'b0;
        endcase
    endfunction

    task automatic model_store(input mem_op_t o, input word_t a, input word_t d);
        int base;
        int k;
        base = {a[`DMEM_ADDR_BITS+1:2], 2'b00};
        k = a[1:0];
        case (o)
            SW: for (int j = 0; j < 4; j++) ref_mem[base+j] = d[8*j +: 8];
            SH: for (int j = 0; j < 2; j++) ref_mem[base+k+j] = d[8*j +: 8];
            SB: ref_mem[base+k] = d[7:0];
            SWL: for (int j = 0; j <= k; j++) ref_mem[base+j] = d[8*(3-k+j) +: 8];
            SWR: for (int j = k; j < 4; j++) ref_mem[base+j] = d[8*(j-k) +: 8];
            default: ;
        endcase
    endtask

    function automatic word_t model_load(input mem_op_t o, input word_t a, input word_t r);
        int          base;
        int          k;
        byte_t       b;
        logic [15:0] h;
        word_t       res;
        base = {a[`DMEM_ADDR_BITS+1:2], 2'b00};
        k = a[1:0];
        b = ref_mem[base+k];
        h = {ref_mem[base+(k|1)], ref_mem[base+(k&2)]};
        res = r;
        case (o)
            LB: res = {{24{b[7]}}, b};
            LBU: res = {24'h000000, b};
            LH: res = {{16{h[15]}}, h};
            LHU: res = {16'h0000, h};
            LW: for (int j = 0; j < 4; j++) res[8*j +: 8] = ref_mem[base+j];
            LWL: for (int j = 0; j <= k; j++) res[8*(3-k+j) +: 8] = ref_mem[base+j];
            LWR: for (int j = k; j < 4; j++) res[8*(j-k) +: 8] = ref_mem[base+j];
            default: res = 32'h0;
        endcase
        return res;
    endfunction

    task automatic check_pending();
        compare("rdata_valid", {31'b0, pending}, {31'b0, rdata_valid});
        if (pending) begin
            compare("rdata", pending_word, rdata);
        end
    endtask

    // One request cycle; the previous load's result is checked in this cycle
    task automatic request(input mem_op_t o, input word_t a, input word_t d);
        logic bad;
        @(posedge clk);
        #1;
        req  = 1'b1;
        op   = o;
        addr = a;
        srcb = d;
        @(negedge clk);
        check_pending();
        bad = expect_error(o, a[1:0]);
        compare("addr_error", {31'b0, bad}, {31'b0, addr_error});
        pending = op_loads(o) && !bad;
        if (pending) begin
            pending_word = model_load(o, a, d);
        end
        if (op_stores(o) && !bad) begin
            model_store(o, a, d);
        end
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
        req = 1'b0;
        op  = NOP;
        @(negedge clk);
        check_pending();
        pending = 1'b0;
    endtask

    task automatic word_round_trip();
        word_t a [WORD_TRIPS];
        test_name = "word_round_trip";
        for (int i = 0; i < WORD_TRIPS; i++) begin
            a[i] = ($urandom % `DMEM_WORDS) << 2;
            request(SW, a[i], $urandom);
        end
        for (int i = 0; i < WORD_TRIPS; i++) request(LW, a[i], 32'h0);
        idle();
    endtask

    task automatic byte_half_stores();
        word_t base;
        test_name = "byte_half_stores";
        base = 32'h0000_0040;
        for (int k = 0; k < 4; k++) begin
            request(SW, base, 32'h1122_3344);
            request(SB, base + k, $urandom);
            request(LW, base, 32'h0);
        end
        for (int k = 0; k < 4; k += 2) begin
            request(SW, base, 32'hCAFE_F00D);
            request(SH, base + k, $urandom);
            request(LW, base, 32'h0);
        end
        idle();
    endtask

    task automatic extending_loads();
        word_t patterns [2];
        word_t base;
        test_name = "extending_loads";
        patterns = '{32'h8F7E_F1A5, 32'h7F80_01FF};
        base = 32'h0000_0080;
        foreach (patterns[p]) begin
            request(SW, base, patterns[p]);
            for (int k = 0; k < 4; k++) begin
                request(LB, base + k, 32'h0);
                request(LBU, base + k, 32'h0);
            end
            for (int k = 0; k < 4; k += 2) begin
                request(LH, base + k, 32'h0);
                request(LHU, base + k, 32'h0);
            end
        end
        idle();
    endtask

    task automatic unaligned_pairs();
        word_t base;
        test_name = "unaligned_pairs";
        base = 32'h0000_00C0;
        for (int k = 0; k < 4; k++) begin
            request(SW, base, 32'h1122_3344);
            request(SWL, base + k, 32'hA1B2_C3D4);
            request(LW, base, 32'h0);
            request(SW, base, 32'h1122_3344);
            request(SWR, base + k, 32'hA1B2_C3D4);
            request(LW, base, 32'h0);
        end
        request(SW, base, 32'h5566_7788);
        for (int k = 0; k < 4; k++) begin
            request(LWL, base + k, 32'hDEAD_BEEF);
            request(LWR, base + k, 32'hDEAD_BEEF);
        end
        idle();
    endtask

    task automatic misalignment();
        word_t base;
        test_name = "misalignment";
        base = 32'h0000_0100;
        request(SW, base, 32'h0BAD_F00D);
        for (int k = 1; k < 4; k++) request(LW, base + k, 32'h0);
        request(SH, base + 1, 32'hFFFF_FFFF); // Must not write
        request(SH, base + 3, 32'hFFFF_FFFF);
        request(LW, base, 32'h0);
        idle();
    endtask

    task automatic back_to_back();
        mem_op_t ops [12];
        mem_op_t o;
        word_t   a;
        ops = '{LB, LBU, LH, LHU, LW, LWL, LWR, SB, SH, SW, SWL, SWR};
        test_name = "back_to_back";
        for (int w = 0; w < 4; w++) request(SW, (32 + w) << 2, $urandom);
        for (int i = 0; i < MIXED_OPS; i++) begin
            o = ops[$urandom % 12];
            a = (32 + $urandom % 4) << 2;
            case (o)
                LW, SW: ;
                LH, LHU, SH: a = a + ($urandom % 2) * 2;
                default: a = a + $urandom % 4;
            endcase
            request(o, a, $urandom);
        end
        request(SW, 32'h0000_0084, 32'h1357_9BDF);
        request(LW, 32'h0000_0084, 32'h0); // Sees the store of the cycle before
        idle();
    endtask

    initial begin
        void'($urandom(32'hef2c_457f));
        pending = 1'b0;
        reset   = 1'b1;
        req     = 1'b0;
        op      = NOP;
        addr    = 32'h0;
        srcb    = 32'h0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        word_round_trip();
        byte_half_stores();
        extending_loads();
        unaligned_pairs();
        misalignment();
        back_to_back();
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire
